// ==== aspect_ratio_sel.sv ====
// ====================
// Aspect ratio select
// Core ratio from standard and crop, manual modes on top
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "n64_glue_settings.svh"

module aspect_ratio_sel import n64_glue_pkg::*; (
	input logic clk_1x,
	input logic RESET,
	input logic pal_select,
	input logic blanks_off,
	input crop_t crop,
	input logic [1:0] ar_mode,
	output ar_size_t video_arx,
	output ar_size_t video_ary
);

	ar_size_t core_x;
	ar_size_t core_y;
	logic [1:0] manual_x;

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			core_x <= `AR_BLANKS_OFF_X;
			core_y <= `AR_BLANKS_OFF_Y;
		end else if (blanks_off) begin
			core_x <= `AR_BLANKS_OFF_X;
			core_y <= `AR_BLANKS_OFF_Y;
		end else if (pal_select) begin
			// Crop 3 keeps the last ratio
			case (crop)
				2'd0: begin
					core_x <= `AR_PAL_CROP0_X;
					core_y <= `AR_PAL_CROP0_Y;
				end
				2'd1: begin
					core_x <= `AR_PAL_CROP1_X;
					core_y <= `AR_PAL_CROP1_Y;
				end
				2'd2: begin
					core_x <= `AR_PAL_CROP2_X;
					core_y <= `AR_PAL_CROP2_Y;
				end
				default: begin
					core_x <= core_x;
					core_y <= core_y;
				end
			endcase
		end else begin
			case (crop)
				2'd0: begin
					core_x <= `AR_NTSC_CROP0_X;
					core_y <= `AR_NTSC_CROP0_Y;
				end
				2'd1: begin
					core_x <= `AR_NTSC_CROP1_X;
					core_y <= `AR_NTSC_CROP1_Y;
				end
				2'd2: begin
					core_x <= `AR_NTSC_CROP2_X;
					core_y <= `AR_NTSC_CROP2_Y;
				end
				default: begin
					core_x <= core_x;
					core_y <= core_y;
				end
			endcase
		end
	end

	// Manual modes pass mode minus one as X with Y zero
	assign manual_x = ar_mode - 2'd1;
	assign video_arx = (ar_mode == 2'd0) ? core_x : {11'd0, manual_x};
	assign video_ary = (ar_mode == 2'd0) ? core_y : '0;

endmodule

`default_nettype wire

// ==== cart_ram_loader.sv ====
// ====================
// Cartridge RAM loader
// Game Boy words into RAM under valid/ready, N64 download end detection
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "n64_glue_settings.svh"

module cart_ram_loader import n64_glue_pkg::*; (
	input logic clk_1x,
	input logic RESET,
	input logic dl_active,
	input dl_index_t dl_index,
	input dl_addr_t dl_addr,
	input dl_data_t dl_data,
	input logic dl_wr,
	input logic ram_wr_ready,
	output logic dl_wait,
	output dl_addr_t ram_wr_addr,
	output ram_word_t ram_wr_data,
	output logic ram_wr_valid,
	output logic romcopy_start,
	output dl_addr_t romcopy_size,
	output logic cart_loaded
);

	logic gb_download;
	logic n64_download;
	logic dl_active_d;
	logic n64_end;
	logic gb_word_done;

	// Falling edge of dl_active while the N64 slot is selected
	assign n64_end = !dl_active && dl_active_d && (dl_index[5:0] == `DL_INDEX_N64);
	assign gb_word_done = gb_download && dl_wr && dl_addr[1];

	// Source is stalled for as long as a word is pending
	assign dl_wait = ram_wr_valid;

	// ====================
	// Control
	// ====================
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			gb_download <= 1'b0;
			n64_download <= 1'b0;
			dl_active_d <= 1'b0;
			romcopy_start <= 1'b0;
			cart_loaded <= 1'b0;
			ram_wr_valid <= 1'b0;
		end else begin
			gb_download <= dl_active && (dl_index[5:0] == `DL_INDEX_GB);
			n64_download <= dl_active && (dl_index[5:0] == `DL_INDEX_N64);
			dl_active_d <= dl_active;
			romcopy_start <= n64_end;
			if (n64_download) begin
				cart_loaded <= 1'b1;
			end
			// Transfer on the edge with valid and ready both high
			if (ram_wr_valid && ram_wr_ready) begin
				ram_wr_valid <= 1'b0;
			end
			if (gb_word_done) begin
				ram_wr_valid <= 1'b1;
			end
		end
	end

	// ====================
	// Payload
	// ====================
	always_ff @(posedge clk_1x) begin
		if (gb_download && dl_wr) begin
			if (!dl_addr[1]) begin
				ram_wr_data[15:0] <= dl_data;
				ram_wr_addr <= dl_addr + `GB_RAM_BASE;
			end else begin
				ram_wr_data[31:16] <= dl_data;
			end
		end
		if (n64_end) begin
			romcopy_size <= dl_addr;
		end
	end

	// Pending word stays put under back-pressure
	a_ram_wr_hold: assert property (@(posedge clk_1x) disable iff (!RESET)
		(ram_wr_valid && !ram_wr_ready) |=>
		(ram_wr_valid && $stable(ram_wr_addr) && $stable(ram_wr_data)));

endmodule

`default_nettype wire

// ==== n64_glue_pkg.sv ====
// ====================
// N64 board glue types
// Shared vector widths and the PLL sequencer states
// ====================
`default_nettype none

package n64_glue_pkg;

	// ====================
	// Download port
	// ====================
	// Bit 6 selects the PIFROM bank
	typedef logic [7:0] dl_index_t;
	typedef logic [26:0] dl_addr_t;
	typedef logic [15:0] dl_data_t;

	// Word written to PIFROM or RAM
	typedef logic [31:0] ram_word_t;
	typedef logic [9:0] pif_addr_t;

	// ====================
	// Video
	// ====================
	typedef logic [12:0] ar_size_t;
	typedef logic [1:0] crop_t;

	// PLL reconfiguration bus
	typedef logic [5:0] cfg_addr_t;
	typedef logic [31:0] cfg_data_t;

	typedef enum logic [1:0] {
		IDLE,
		WR_MODE,
		WR_MFRAC,
		WR_START
	} pll_seq_state_t;

endpackage

`default_nettype wire

// ==== n64_glue_settings.svh ====
// ====================
// N64 board glue constants
// Download slots, RAM base, PLL registers and aspect ratio tables
// ====================
`ifndef N64_GLUE_SETTINGS_SVH
`define N64_GLUE_SETTINGS_SVH

// Download slots, compared against index bits 5:0
`define DL_INDEX_PIFROM 6'd0
`define DL_INDEX_N64 6'd1
`define DL_INDEX_GB 6'd2

// Game Boy cartridge area in RAM
`define GB_RAM_BASE 27'd8388608

// PLL reconfiguration registers
`define PLL_REG_MODE 6'd0
`define PLL_REG_MFRAC 6'd7
`define PLL_REG_START 6'd2
`define PLL_MFRAC_PAL 32'd4024384270
`define PLL_MFRAC_NTSC 32'd3274482981

// Core aspect ratios, X then Y
`define AR_BLANKS_OFF_X 13'd4
`define AR_BLANKS_OFF_Y 13'd3
`define AR_PAL_CROP0_X 13'd512
`define AR_PAL_CROP0_Y 13'd387
`define AR_PAL_CROP1_X 13'd1024
`define AR_PAL_CROP1_Y 13'd731
`define AR_PAL_CROP2_X 13'd2048
`define AR_PAL_CROP2_Y 13'd1419
`define AR_NTSC_CROP0_X 13'd512
`define AR_NTSC_CROP0_Y 13'd381
`define AR_NTSC_CROP1_X 13'd1280
`define AR_NTSC_CROP1_Y 13'd889
`define AR_NTSC_CROP2_X 13'd2560
`define AR_NTSC_CROP2_Y 13'd1714

`endif

// ==== n64_glue_top.sv ====
// ====================
// N64 board glue top
// Download loaders, PLL sequencer and aspect ratio select
// ====================
`timescale 1ns/1ps
`default_nettype none

module n64_glue_top import n64_glue_pkg::*; (
	input logic clk_1x,
	input logic RESET,
	// Download source
	input logic dl_active,
	input dl_index_t dl_index,
	input dl_addr_t dl_addr,
	input dl_data_t dl_data,
	input logic dl_wr,
	output logic dl_wait,
	// PIFROM write port
	output pif_addr_t pif_addr,
	output ram_word_t pif_data,
	output logic pif_wren,
	// RAM write port
	output dl_addr_t ram_wr_addr,
	output ram_word_t ram_wr_data,
	output logic ram_wr_valid,
	input logic ram_wr_ready,
	// Cartridge status
	output logic romcopy_start,
	output dl_addr_t romcopy_size,
	output logic cart_loaded,
	// Video standard and PLL bus
	input logic pal_select,
	input logic cfg_waitrequest,
	output logic cfg_write,
	output cfg_addr_t cfg_address,
	output cfg_data_t cfg_data,
	// Aspect ratio
	input logic blanks_off,
	input crop_t crop,
	input logic [1:0] ar_mode,
	output ar_size_t video_arx,
	output ar_size_t video_ary
);

	pifrom_loader i_pifrom_loader (
		.clk_1x(clk_1x),
		.RESET(RESET),
		.dl_active(dl_active),
		.dl_index(dl_index),
		.dl_addr(dl_addr),
		.dl_data(dl_data),
		.dl_wr(dl_wr),
		.pif_addr(pif_addr),
		.pif_data(pif_data),
		.pif_wren(pif_wren)
	);

	cart_ram_loader i_cart_ram_loader (
		.clk_1x(clk_1x),
		.RESET(RESET),
		.dl_active(dl_active),
		.dl_index(dl_index),
		.dl_addr(dl_addr),
		.dl_data(dl_data),
		.dl_wr(dl_wr),
		.ram_wr_ready(ram_wr_ready),
		.dl_wait(dl_wait),
		.ram_wr_addr(ram_wr_addr),
		.ram_wr_data(ram_wr_data),
		.ram_wr_valid(ram_wr_valid),
		.romcopy_start(romcopy_start),
		.romcopy_size(romcopy_size),
		.cart_loaded(cart_loaded)
	);

	pll_reconfig_seq i_pll_reconfig_seq (
		.clk_1x(clk_1x),
		.RESET(RESET),
		.pal_select(pal_select),
		.cfg_waitrequest(cfg_waitrequest),
		.cfg_write(cfg_write),
		.cfg_address(cfg_address),
		.cfg_data(cfg_data)
	);

	aspect_ratio_sel i_aspect_ratio_sel (
		.clk_1x(clk_1x),
		.RESET(RESET),
		.pal_select(pal_select),
		.blanks_off(blanks_off),
		.crop(crop),
		.ar_mode(ar_mode),
		.video_arx(video_arx),
		.video_ary(video_ary)
	);

endmodule

`default_nettype wire

// ==== pifrom_loader.sv ====
// ====================
// PIFROM loader
// Packs byte-swapped boot-ROM half-words into 32-bit words
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "n64_glue_settings.svh"

module pifrom_loader import n64_glue_pkg::*; (
	input logic clk_1x,
	input logic RESET,
	input logic dl_active,
	input dl_index_t dl_index,
	input dl_addr_t dl_addr,
	input dl_data_t dl_data,
	input logic dl_wr,
	output pif_addr_t pif_addr,
	output ram_word_t pif_data,
	output logic pif_wren
);

	// Download active under the PIFROM slot
	logic pif_download;
	logic second_half;

	assign second_half = dl_addr[1];

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			pif_download <= 1'b0;
			pif_wren <= 1'b0;
		end else begin
			pif_download <= dl_active && (dl_index[5:0] == `DL_INDEX_PIFROM);
			// Strobe once the second half of a word arrives
			pif_wren <= pif_download && dl_wr && second_half;
		end
	end

	// Word assembly, bytes swapped inside each half-word
	always_ff @(posedge clk_1x) begin
		if (pif_download && dl_wr) begin
			if (!second_half) begin
				pif_data[31:24] <= dl_data[7:0];
				pif_data[23:16] <= dl_data[15:8];
				// Bank bit in front of the word address
				pif_addr <= {dl_index[6], dl_addr[10:2]};
			end else begin
				pif_data[15:8] <= dl_data[7:0];
				pif_data[7:0] <= dl_data[15:8];
			end
		end
	end

endmodule

`default_nettype wire

// ==== pll_reconfig_seq.sv ====
// ====================
// PLL reconfiguration sequencer
// Writes MODE, MFRAC and START when the video standard changes
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "n64_glue_settings.svh"

module pll_reconfig_seq import n64_glue_pkg::*; (
	input logic clk_1x,
	input logic RESET,
	input logic pal_select,
	input logic cfg_waitrequest,
	output logic cfg_write,
	output cfg_addr_t cfg_address,
	output cfg_data_t cfg_data
);

	logic pal_d;
	logic pal_d2;
	logic pal_change;
	pll_seq_state_t state;

	// Standard change seen between the two stages
	assign pal_change = (pal_d != pal_d2);

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			pal_d <= 1'b0;
			pal_d2 <= 1'b0;
			state <= IDLE;
			cfg_write <= 1'b0;
		end else begin
			pal_d <= pal_select;
			pal_d2 <= pal_d;
			if (pal_change) begin
				// Restart from the first write
				state <= WR_MODE;
				cfg_write <= 1'b1;
				cfg_address <= `PLL_REG_MODE;
				cfg_data <= '0;
			end else if (cfg_write) begin
				// Accepted once waitrequest is low
				if (!cfg_waitrequest) begin
					cfg_write <= 1'b0;
				end
			end else begin
				// One idle cycle between writes
				case (state)
					WR_MODE: begin
						state <= WR_MFRAC;
						cfg_write <= 1'b1;
						cfg_address <= `PLL_REG_MFRAC;
						cfg_data <= pal_d2 ? `PLL_MFRAC_PAL : `PLL_MFRAC_NTSC;
					end
					WR_MFRAC: begin
						state <= WR_START;
						cfg_write <= 1'b1;
						cfg_address <= `PLL_REG_START;
						cfg_data <= '0;
					end
					WR_START: begin
						state <= IDLE;
					end
					IDLE: begin
						state <= IDLE;
					end
				endcase
			end
		end
	end

	a_cfg_hold: assert property (@(posedge clk_1x) disable iff (!RESET)
		(cfg_write && cfg_waitrequest && !pal_change) |=>
		(cfg_write && $stable(cfg_address) && $stable(cfg_data)));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the N64 glue testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module tb_n64_glue -o tb_n64_glue
./obj_dir/tb_n64_glue | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== sim.f ====
+incdir+.
n64_glue_pkg.sv
pifrom_loader.sv
cart_ram_loader.sv
pll_reconfig_seq.sv
aspect_ratio_sel.sv
n64_glue_top.sv
tb_n64_glue.sv

// ==== tb_n64_glue.sv ====
// ====================
// N64 board glue testbench
// Table-driven checks of both loaders, the PLL sequencer and aspect ratio
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_n64_glue import n64_glue_pkg::*; ();

	logic clk_1x = 1'b0;
	logic RESET = 1'b0;
	logic dl_active = 1'b0;
	dl_index_t dl_index = '0;
	dl_addr_t dl_addr = '0;
	dl_data_t dl_data = '0;
	logic dl_wr = 1'b0;
	logic ram_wr_ready = 1'b0;
	logic pal_select = 1'b0;
	logic cfg_waitrequest = 1'b0;
	logic blanks_off = 1'b0;
	crop_t crop = '0;
	logic [1:0] ar_mode = '0;

	logic dl_wait, pif_wren, ram_wr_valid, romcopy_start, cart_loaded, cfg_write;
	pif_addr_t pif_addr;
	ram_word_t pif_data, ram_wr_data;
	dl_addr_t ram_wr_addr, romcopy_size;
	cfg_addr_t cfg_address;
	cfg_data_t cfg_data;
	ar_size_t video_arx, video_ary;

	int value_errors = 0;
	int other_errors = 0;
	integer seed = 32'h2465;
	integer rnd;

	// Words and writes accepted by the RAM and PLL bus side
	ram_word_t gb_data_q[$];
	dl_addr_t gb_addr_q[$];
	cfg_addr_t cfg_addr_q[$];
	cfg_data_t cfg_data_q[$];

	// ====================
	// Tables
	// ====================
	// pal, blanks_off, crop, ar_mode, expected X, expected Y
	logic [31:0] ar_tab [13] = '{
		{1'b0, 1'b0, 2'd0, 2'd0, 13'd512, 13'd381},
		{1'b0, 1'b0, 2'd1, 2'd0, 13'd1280, 13'd889},
		{1'b0, 1'b0, 2'd2, 2'd0, 13'd2560, 13'd1714},
		{1'b1, 1'b0, 2'd0, 2'd0, 13'd512, 13'd387},
		{1'b1, 1'b0, 2'd1, 2'd0, 13'd1024, 13'd731},
		{1'b1, 1'b0, 2'd2, 2'd0, 13'd2048, 13'd1419},
		{1'b1, 1'b0, 2'd3, 2'd0, 13'd2048, 13'd1419},
		{1'b0, 1'b0, 2'd3, 2'd0, 13'd2048, 13'd1419},
		{1'b0, 1'b1, 2'd0, 2'd0, 13'd4, 13'd3},
		{1'b0, 1'b0, 2'd1, 2'd1, 13'd0, 13'd0},
		{1'b1, 1'b0, 2'd2, 2'd2, 13'd1, 13'd0},
		{1'b1, 1'b1, 2'd2, 2'd3, 13'd2, 13'd0},
		{1'b1, 1'b0, 2'd2, 2'd0, 13'd2048, 13'd1419}
	};

	// index, byte address, first half, second half, expected word, expected word address
	logic [108:0] pif_tab [4] = '{
		{8'h00, 27'h000, 16'h1234, 16'h5678, 32'h34127856, 10'h000},
		{8'h00, 27'h004, 16'habcd, 16'hef01, 32'hcdab01ef, 10'h001},
		{8'h40, 27'h008, 16'h8037, 16'h1240, 32'h37804012, 10'h202},
		{8'h40, 27'h7fc, 16'h0f0f, 16'ha55a, 32'h0f0f5aa5, 10'h3ff}
	};

	// byte address, first half, second half, expected word, expected RAM address
	logic [117:0] gb_tab [5] = '{
		{27'h000000, 16'h0100, 16'h0302, 32'h03020100, 27'h800000},
		{27'h000004, 16'h1111, 16'h2222, 32'h22221111, 27'h800004},
		{27'h000008, 16'hdead, 16'hbeef, 32'hbeefdead, 27'h800008},
		{27'h001000, 16'hcafe, 16'hf00d, 32'hf00dcafe, 27'h801000},
		{27'h0ffffc, 16'h0055, 16'haa00, 32'haa000055, 27'h8ffffc}
	};

	// New standard and its MFRAC value
	logic [32:0] pll_tab [2] = '{{1'b0, 32'd3274482981}, {1'b1, 32'd4024384270}};

	n64_glue_top i_dut (.*);

	always #4 clk_1x = ~clk_1x;

	// RAM and PLL bus side with random back-pressure
	always @(posedge clk_1x) begin
		#1;
		rnd = $random(seed);
		ram_wr_ready = rnd[0];
		cfg_waitrequest = rnd[1];
		// Both high now means a transfer on the coming edge
		if (ram_wr_valid && ram_wr_ready) begin
			gb_data_q.push_back(ram_wr_data);
			gb_addr_q.push_back(ram_wr_addr);
		end
		if (cfg_write && !cfg_waitrequest) begin
			cfg_addr_q.push_back(cfg_address);
			cfg_data_q.push_back(cfg_data);
		end
	end

	// ====================
	// Helpers
	// ====================
	task automatic next_cycle();
		@(posedge clk_1x);
		#1;
	endtask

	task automatic report_timeout(input string what);
		other_errors++;
		$display("ERROR: timed out waiting for %s at %0t", what, $time);
	endtask

	task automatic report_error(input string what);
		other_errors++;
		$display("ERROR: %s at %0t", what, $time);
	endtask

	task automatic check_word(input string name, input ram_word_t got, input ram_word_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input dl_addr_t got, input dl_addr_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_ar(input string name, input ar_size_t got, input ar_size_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_cfg(input string name, input cfg_data_t got, input cfg_data_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic send_half(input dl_addr_t addr, input dl_data_t data);
		dl_addr = addr;
		dl_data = data;
		dl_wr = 1'b1;
		next_cycle();
		dl_wr = 1'b0;
	endtask

	// No write in the first cycle of a download
	task automatic start_download(input dl_index_t idx);
		dl_active = 1'b0;
		next_cycle();
		dl_index = idx;
		dl_active = 1'b1;
		next_cycle();
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin : main
		dl_addr_t a;
		int i;
		int n;
		int base;
		int pulses;
		int quiet;
		repeat (4) @(posedge clk_1x);
		#1;
		RESET = 1'b1;

		// Aspect ratio
		for (i = 0; i < 13; i++) begin
			{pal_select, blanks_off, crop, ar_mode} = ar_tab[i][31:26];
			repeat (2) next_cycle();
			check_ar("video_arx", video_arx, ar_tab[i][25:13]);
			check_ar("video_ary", video_ary, ar_tab[i][12:0]);
		end

		// PIFROM download, bank 0 then bank 1
		for (i = 0; i < 4; i++) begin
			if (!dl_active || dl_index != pif_tab[i][108:101]) begin
				start_download(pif_tab[i][108:101]);
			end
			send_half(pif_tab[i][100:74], pif_tab[i][73:58]);
			send_half(pif_tab[i][100:74] + 27'd2, pif_tab[i][57:42]);
			n = 0;
			while (!pif_wren && n < 10) begin
				next_cycle();
				n++;
			end
			if (!pif_wren) begin
				report_timeout("pif_wren");
			end else begin
				check_word("pif_data", pif_data, pif_tab[i][41:10]);
				check_addr("pif_addr", {17'd0, pif_addr}, {17'd0, pif_tab[i][9:0]});
				next_cycle();
				if (pif_wren) begin
					report_error("pif_wren high for more than one cycle");
				end
			end
		end
		dl_active = 1'b0;
		next_cycle();

		// Game Boy download under RAM back-pressure
		start_download(8'd2);
		for (i = 0; i < 5; i++) begin
			send_half(gb_tab[i][117:91], gb_tab[i][90:75]);
			send_half(gb_tab[i][117:91] + 27'd2, gb_tab[i][74:59]);
			n = 0;
			while (dl_wait && n < 100) begin
				next_cycle();
				n++;
			end
			if (dl_wait) begin
				report_timeout("dl_wait to fall");
			end
		end
		dl_active = 1'b0;
		repeat (4) next_cycle();
		if (gb_data_q.size() != 5) begin
			report_error($sformatf("%0d RAM writes seen where 5 were sent", gb_data_q.size()));
		end
		for (i = 0; i < 5 && i < gb_data_q.size(); i++) begin
			check_word("ram_wr_data", gb_data_q[i], gb_tab[i][58:27]);
			check_addr("ram_wr_addr", gb_addr_q[i], gb_tab[i][26:0]);
		end

		// N64 cartridge download end
		if (cart_loaded !== 1'b0) begin
			report_error("cart_loaded set before any N64 download");
		end
		start_download(8'd1);
		a = 27'h1f8;
		repeat (4) begin
			send_half(a, a[15:0]);
			a = a + 27'd2;
		end
		dl_active = 1'b0;
		n = 0;
		while (!romcopy_start && n < 20) begin
			next_cycle();
			n++;
		end
		if (!romcopy_start) begin
			report_timeout("romcopy_start");
		end
		pulses = 0;
		repeat (8) begin
			if (romcopy_start) begin
				pulses++;
			end
			next_cycle();
		end
		if (pulses != 1) begin
			report_error($sformatf("%0d romcopy_start pulses where one was expected", pulses));
		end
		check_addr("romcopy_size", romcopy_size, 27'h1fe);
		if (cart_loaded !== 1'b1) begin
			report_error("cart_loaded not set after the N64 download");
		end

		// PLL reconfiguration, to NTSC then back to PAL
		for (i = 0; i < 2; i++) begin
			// Idle once no write is seen for a few cycles
			n = 0;
			quiet = 0;
			while (quiet < 4 && n < 200) begin
				quiet = cfg_write ? 0 : quiet + 1;
				next_cycle();
				n++;
			end
			if (quiet < 4) begin
				report_timeout("PLL sequencer to go idle");
			end
			base = cfg_addr_q.size();
			pal_select = pll_tab[i][32];
			n = 0;
			while (!(cfg_addr_q.size() >= base + 3 && !cfg_write) && n < 200) begin
				next_cycle();
				n++;
			end
			if (cfg_addr_q.size() < base + 3 || cfg_write) begin
				report_timeout("end of the PLL write sequence");
			end
			repeat (4) next_cycle();
			if (cfg_addr_q.size() != base + 3) begin
				report_error($sformatf("%0d PLL writes accepted where 3 were expected",
					cfg_addr_q.size() - base));
			end else begin
				check_cfg("cfg_address", {26'd0, cfg_addr_q[base]}, 32'd0);
				check_cfg("cfg_data", cfg_data_q[base], 32'd0);
				check_cfg("cfg_address", {26'd0, cfg_addr_q[base + 1]}, 32'd7);
				check_cfg("cfg_data", cfg_data_q[base + 1], pll_tab[i][31:0]);
				check_cfg("cfg_address", {26'd0, cfg_addr_q[base + 2]}, 32'd2);
				check_cfg("cfg_data", cfg_data_q[base + 2], 32'd0);
			end
		end

		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire
